// ==== src/rob_pkg.sv ====
// sizes assume WAYS is a power of two and ROB_ENTRIES is an exact multiple of WAYS
package rob_pkg;

    // ----------------------------------------
    // sizes

    // ways per dispatch row
    localparam int WAYS = 4;

    // total entries and rows
    localparam int ROB_ENTRIES = 32;
    localparam int ROB_ROWS = ROB_ENTRIES / WAYS;

    // index widths
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);
    localparam int LOG_ROB_ROWS = $clog2(ROB_ROWS);

    // physical register number width
    localparam int LOG_PR_COUNT = 7;

    // writeback bus banks feeding completion notices
    localparam int PRF_BANK_COUNT = 2;

    // ----------------------------------------
    // types

    // entry index is {row, way}
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
    typedef logic [LOG_ROB_ROWS-1:0] row_index_t;

    // one bit per way of a row
    typedef logic [WAYS-1:0] way_mask_t;

    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef pr_t [WAYS-1:0] pr_by_way_t;

    // commit stage waits on head completion, then drains register frees
    typedef enum logic {
        COMMIT_WAIT,
        COMMIT_FREE
    } commit_state_t;

    // ----------------------------------------
    // helpers shared by head and tail logic

    // row pointer step, wraps after the last row
    function automatic row_index_t next_row(row_index_t row);
        return (row == row_index_t'(ROB_ROWS - 1)) ? '0 : row + 1'b1;
    endfunction

    // flat entry index of one way within a row
    function automatic rob_index_t entry_index(row_index_t row, int way);
        return rob_index_t'(row * WAYS + way);
    endfunction

endpackage

// ==== src/rob_alloc_if.sv ====
// alloc_valid may only be raised while tail_busy is low, the row is written at that edge
`timescale 1ns/10ps

interface rob_alloc_if;

    // enqueue strobe and target row
    logic alloc_valid;
    rob_pkg::row_index_t alloc_row;

    // row fields kept for commit and free
    rob_pkg::way_mask_t valid_by_way;
    rob_pkg::way_mask_t is_rename_by_way;
    rob_pkg::way_mask_t is_ldu_by_way;
    rob_pkg::pr_by_way_t old_pr_by_way;

    // valid bit of the row named by alloc_row
    logic tail_busy;

    // producer side
    modport dispatch_mp (
        output alloc_valid,
        output alloc_row,
        output valid_by_way,
        output is_rename_by_way,
        output is_ldu_by_way,
        output old_pr_by_way,
        input tail_busy
    );

    // buffer side
    modport store_mp (
        input alloc_valid,
        input alloc_row,
        input valid_by_way,
        input is_rename_by_way,
        input is_ldu_by_way,
        input old_pr_by_way,
        output tail_busy
    );

endinterface

// ==== src/rob_head_if.sv ====
// head view is combinational from head_row, deq clears the head row at the same edge
`timescale 1ns/10ps

interface rob_head_if;

    // head pointer from commit
    rob_pkg::row_index_t head_row;

    // head row state
    logic head_valid;
    logic head_complete;

    // head row fields
    rob_pkg::way_mask_t valid_by_way;
    rob_pkg::way_mask_t is_rename_by_way;
    rob_pkg::pr_by_way_t old_pr_by_way;

    // row leaves the buffer
    logic deq;

    // buffer side
    modport store_mp (
        input head_row,
        output head_valid,
        output head_complete,
        output valid_by_way,
        output is_rename_by_way,
        output old_pr_by_way,
        input deq
    );

    // consumer side
    modport commit_mp (
        output head_row,
        input head_valid,
        input head_complete,
        input valid_by_way,
        input is_rename_by_way,
        input old_pr_by_way,
        output deq
    );

endinterface

// ==== src/rob_dispatch.sv ====
// one row per cycle, index outputs are valid in the enqueue cycle whether or not it is accepted
`timescale 1ns/10ps

module rob_dispatch (
    input logic CLK,
    input logic nRST,

    // dispatch row
    input logic dispatch_enq_valid,
    input rob_pkg::way_mask_t dispatch_valid_by_way,
    input rob_pkg::way_mask_t dispatch_is_rename_by_way,
    input rob_pkg::way_mask_t dispatch_is_ldu_by_way,
    input rob_pkg::pr_by_way_t dispatch_old_pr_by_way,

    // feedback to dispatch
    output logic dispatch_enq_ready,
    output rob_pkg::rob_index_t [rob_pkg::WAYS-1:0] dispatch_rob_index_by_way,

    // row write toward the buffer
    rob_alloc_if.dispatch_mp alloc
);

    // ----------------------------------------
    // tail pointer

    rob_pkg::row_index_t tail_row;

    // accepted enqueue this cycle
    logic enq_fire;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            tail_row <= '0;
        end else if (enq_fire) begin
            tail_row <= rob_pkg::next_row(tail_row);
        end
    end

    // ----------------------------------------
    // acceptance and row forwarding

    always_comb begin
        // tail row must have been retired before reuse
        dispatch_enq_ready = ~alloc.tail_busy;
        enq_fire = dispatch_enq_valid & dispatch_enq_ready;

        // write strobe only on accepted rows
        alloc.alloc_valid = enq_fire;
        alloc.alloc_row = tail_row;

        alloc.valid_by_way = dispatch_valid_by_way;
        alloc.is_rename_by_way = dispatch_is_rename_by_way;
        alloc.is_ldu_by_way = dispatch_is_ldu_by_way;
        alloc.old_pr_by_way = dispatch_old_pr_by_way;

        // each way gets {tail row, way}
        for (int w = 0; w < rob_pkg::WAYS; w++) begin
            dispatch_rob_index_by_way[w] = rob_pkg::entry_index(tail_row, w);
        end
    end

endmodule

// ==== src/rob_row_store.sv ====
// notices for entries outside live rows are taken but cleared again on enqueue of that row
`timescale 1ns/10ps

module rob_row_store (
    input logic CLK,
    input logic nRST,

    // row write from dispatch
    rob_alloc_if.store_mp alloc,

    // head view for commit
    rob_head_if.store_mp head,

    // writeback bus notices by bank
    input logic [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank,
    input rob_pkg::rob_index_t [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_rob_index_by_bank,

    // load unit notice
    input logic ldu_complete_valid,
    input rob_pkg::rob_index_t ldu_complete_rob_index,

    // store/amo unit notice
    input logic stamofu_complete_valid,
    input rob_pkg::rob_index_t stamofu_complete_rob_index
);

    // ----------------------------------------
    // state

    // one valid bit per row
    logic [rob_pkg::ROB_ROWS-1:0] row_valid;

    // writeback and unit completion kept apart, loads ignore writeback
    logic [rob_pkg::ROB_ENTRIES-1:0] wb_complete;
    logic [rob_pkg::ROB_ENTRIES-1:0] unit_complete;

    // row payload
    rob_pkg::way_mask_t valid_by_way_q [rob_pkg::ROB_ROWS];
    rob_pkg::way_mask_t is_rename_q [rob_pkg::ROB_ROWS];
    rob_pkg::way_mask_t is_ldu_q [rob_pkg::ROB_ROWS];
    rob_pkg::pr_by_way_t old_pr_q [rob_pkg::ROB_ROWS];

    // head row decode
    rob_pkg::way_mask_t head_valid_ways;
    rob_pkg::way_mask_t head_is_ldu;
    rob_pkg::way_mask_t way_complete;

    // ----------------------------------------
    // valid and completion bits

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            row_valid <= '0;
            wb_complete <= '0;
            unit_complete <= '0;
        end else begin
            // new row starts with nothing complete
            if (alloc.alloc_valid) begin
                row_valid[alloc.alloc_row] <= 1'b1;
                for (int w = 0; w < rob_pkg::WAYS; w++) begin
                    wb_complete[rob_pkg::entry_index(alloc.alloc_row, w)] <= 1'b0;
                    unit_complete[rob_pkg::entry_index(alloc.alloc_row, w)] <= 1'b0;
                end
            end

            // retired row frees its slot
            if (head.deq) begin
                row_valid[head.head_row] <= 1'b0;
                for (int w = 0; w < rob_pkg::WAYS; w++) begin
                    wb_complete[rob_pkg::entry_index(head.head_row, w)] <= 1'b0;
                    unit_complete[rob_pkg::entry_index(head.head_row, w)] <= 1'b0;
                end
            end

            // every bank can land in the same cycle
            for (int b = 0; b < rob_pkg::PRF_BANK_COUNT; b++) begin
                if (complete_bus_valid_by_bank[b]) begin
                    wb_complete[complete_bus_rob_index_by_bank[b]] <= 1'b1;
                end
            end

            // unit notices
            if (ldu_complete_valid) begin
                unit_complete[ldu_complete_rob_index] <= 1'b1;
            end
            if (stamofu_complete_valid) begin
                unit_complete[stamofu_complete_rob_index] <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // row payload write

    always_ff @(posedge CLK) begin
        if (alloc.alloc_valid) begin
            valid_by_way_q[alloc.alloc_row] <= alloc.valid_by_way;
            is_rename_q[alloc.alloc_row] <= alloc.is_rename_by_way;
            is_ldu_q[alloc.alloc_row] <= alloc.is_ldu_by_way;
            old_pr_q[alloc.alloc_row] <= alloc.old_pr_by_way;
        end
    end

    // ----------------------------------------
    // tail and head views

    always_comb begin
        rob_pkg::rob_index_t idx;

        // dispatch may reuse a row only once it has retired
        alloc.tail_busy = row_valid[alloc.alloc_row];

        head_valid_ways = valid_by_way_q[head.head_row];
        head_is_ldu = is_ldu_q[head.head_row];

        head.head_valid = row_valid[head.head_row];
        head.valid_by_way = head_valid_ways;
        head.is_rename_by_way = is_rename_q[head.head_row];
        head.old_pr_by_way = old_pr_q[head.head_row];

        // invalid ways count as done
        // a unit notice always completes, writeback only for non-loads
        for (int w = 0; w < rob_pkg::WAYS; w++) begin
            idx = rob_pkg::entry_index(head.head_row, w);
            way_complete[w] = ~head_valid_ways[w]
                | unit_complete[idx]
                | (~head_is_ldu[w] & wb_complete[idx]);
        end
        head.head_complete = &way_complete;
    end

endmodule

// ==== src/rob_commit.sv ====
// one free bank per way, a held ack stalls the head indefinitely
`timescale 1ns/10ps

module rob_commit (
    input logic CLK,
    input logic nRST,

    // head row from the buffer
    rob_head_if.commit_mp head,

    // commit broadcast
    output logic rob_commit_valid,
    output rob_pkg::row_index_t rob_commit_row,
    output rob_pkg::way_mask_t rob_commit_way_mask,

    // physical register free, way w on bank w
    output rob_pkg::way_mask_t rob_pr_free_req_valid,
    output rob_pkg::pr_by_way_t rob_pr_free_req_pr,
    input rob_pkg::way_mask_t rob_pr_free_ack
);

    // ----------------------------------------
    // state

    rob_pkg::commit_state_t state;
    rob_pkg::row_index_t head_row;

    // renaming ways still waiting on an ack
    rob_pkg::way_mask_t pending_free;

    // head row fully complete while idle
    logic commit_fire;

    // all frees done, row leaves
    logic deq_fire;

    // ----------------------------------------
    // control

    always_comb begin
        head.head_row = head_row;

        commit_fire = (state == rob_pkg::COMMIT_WAIT) & head.head_valid & head.head_complete;

        // also true in the commit cycle when no way renames
        deq_fire = (state == rob_pkg::COMMIT_FREE) & (pending_free == '0);
        head.deq = deq_fire;

        // requests only while draining
        rob_pr_free_req_valid = (state == rob_pkg::COMMIT_FREE) ? pending_free : '0;
        rob_pr_free_req_pr = head.old_pr_by_way;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= rob_pkg::COMMIT_WAIT;
            head_row <= '0;
            pending_free <= '0;
            rob_commit_valid <= 1'b0;
        end else begin
            // single cycle pulse, the next one needs a fresh row
            rob_commit_valid <= commit_fire;

            if (commit_fire) begin
                state <= rob_pkg::COMMIT_FREE;
                pending_free <= head.valid_by_way & head.is_rename_by_way;
            end else if (state == rob_pkg::COMMIT_FREE) begin
                if (deq_fire) begin
                    state <= rob_pkg::COMMIT_WAIT;
                    head_row <= rob_pkg::next_row(head_row);
                end else begin
                    // stray acks on idle banks drop out here
                    pending_free <= pending_free & ~rob_pr_free_ack;
                end
            end
        end
    end

    // ----------------------------------------
    // commit payload

    // only meaningful alongside rob_commit_valid
    always_ff @(posedge CLK) begin
        if (commit_fire) begin
            rob_commit_row <= head_row;
            rob_commit_way_mask <= head.valid_by_way;
        end
    end

endmodule

// ==== src/rob_top.sv ====
// in-order retire only, no restart, kill or exception handling
`timescale 1ns/10ps

module rob_top (
    input logic CLK,
    input logic nRST,

    // dispatch
    input logic dispatch_enq_valid,
    input rob_pkg::way_mask_t dispatch_valid_by_way,
    input rob_pkg::way_mask_t dispatch_is_rename_by_way,
    input rob_pkg::way_mask_t dispatch_is_ldu_by_way,
    input rob_pkg::pr_by_way_t dispatch_old_pr_by_way,
    output logic dispatch_enq_ready,
    output rob_pkg::rob_index_t [rob_pkg::WAYS-1:0] dispatch_rob_index_by_way,

    // completion notices
    input logic [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank,
    input rob_pkg::rob_index_t [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_rob_index_by_bank,
    input logic ldu_complete_valid,
    input rob_pkg::rob_index_t ldu_complete_rob_index,
    input logic stamofu_complete_valid,
    input rob_pkg::rob_index_t stamofu_complete_rob_index,

    // commit and register free
    output logic rob_commit_valid,
    output rob_pkg::row_index_t rob_commit_row,
    output rob_pkg::way_mask_t rob_commit_way_mask,
    output rob_pkg::way_mask_t rob_pr_free_req_valid,
    output rob_pkg::pr_by_way_t rob_pr_free_req_pr,
    input rob_pkg::way_mask_t rob_pr_free_ack
);

    // dispatch to buffer
    rob_alloc_if alloc_bus ();

    // buffer to commit
    rob_head_if head_bus ();

    rob_dispatch dispatch_i (
        .CLK(CLK),
        .nRST(nRST),
        .dispatch_enq_valid(dispatch_enq_valid),
        .dispatch_valid_by_way(dispatch_valid_by_way),
        .dispatch_is_rename_by_way(dispatch_is_rename_by_way),
        .dispatch_is_ldu_by_way(dispatch_is_ldu_by_way),
        .dispatch_old_pr_by_way(dispatch_old_pr_by_way),
        .dispatch_enq_ready(dispatch_enq_ready),
        .dispatch_rob_index_by_way(dispatch_rob_index_by_way),
        .alloc(alloc_bus.dispatch_mp)
    );

    rob_row_store store_i (
        .CLK(CLK),
        .nRST(nRST),
        .alloc(alloc_bus.store_mp),
        .head(head_bus.store_mp),
        .complete_bus_valid_by_bank(complete_bus_valid_by_bank),
        .complete_bus_rob_index_by_bank(complete_bus_rob_index_by_bank),
        .ldu_complete_valid(ldu_complete_valid),
        .ldu_complete_rob_index(ldu_complete_rob_index),
        .stamofu_complete_valid(stamofu_complete_valid),
        .stamofu_complete_rob_index(stamofu_complete_rob_index)
    );

    rob_commit commit_i (
        .CLK(CLK),
        .nRST(nRST),
        .head(head_bus.commit_mp),
        .rob_commit_valid(rob_commit_valid),
        .rob_commit_row(rob_commit_row),
        .rob_commit_way_mask(rob_commit_way_mask),
        .rob_pr_free_req_valid(rob_pr_free_req_valid),
        .rob_pr_free_req_pr(rob_pr_free_req_pr),
        .rob_pr_free_ack(rob_pr_free_ack)
    );

endmodule

// ==== dv/tb_clkgen.sv ====
// free-running 4 ns clock, nRST held low for the first two rising edges
`timescale 1ns/10ps

module tb_clkgen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // release just after the second edge so nothing races the reset edge
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

// ==== dv/rob_asserts.sv ====
// bound into every rob_commit instance, checks only the commit and free handshake
`timescale 1ns/10ps

module rob_asserts (
    input logic CLK,
    input logic nRST,
    input rob_pkg::commit_state_t state,
    input logic rob_commit_valid,
    input rob_pkg::way_mask_t rob_pr_free_req_valid,
    input rob_pkg::way_mask_t rob_pr_free_ack,
    input logic deq_fire
);

    // broadcast is a one cycle pulse per retired row
    commit_one_cycle: assert property (
        @(posedge CLK) disable iff (!nRST) rob_commit_valid |=> !rob_commit_valid
    ) else $error("rob_commit_valid stayed high for more than one cycle");

    // new frees appear only with the commit of their row, while it drains
    free_only_draining: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((rob_pr_free_req_valid & ~$past(rob_pr_free_req_valid)) != '0)
            |-> ((state == rob_pkg::COMMIT_FREE) && rob_commit_valid)
    ) else $error("free request raised outside the commit of its row");

    // a request not yet acked stays up, so the row cannot leave on it
    deq_after_frees: assert property (
        @(posedge CLK) disable iff (!nRST)
        deq_fire |-> ($past(rob_pr_free_req_valid & ~rob_pr_free_ack) == '0)
    ) else $error("deq issued while a free request was still pending");

endmodule

bind rob_commit rob_asserts asserts_i (
    .CLK(CLK),
    .nRST(nRST),
    .state(state),
    .rob_commit_valid(rob_commit_valid),
    .rob_pr_free_req_valid(rob_pr_free_req_valid),
    .rob_pr_free_ack(rob_pr_free_ack),
    .deq_fire(deq_fire)
);

// ==== dv/rob_tb.sv ====
// runs the row table twice, the second pass holds free acks until all 8 rows are busy
`timescale 1ns/10ps

module rob_tb;

    // ----------------------------------------
    // run sizes

    localparam int TABLE_LINES = 8;
    localparam int PASSES = 2;
    localparam int CYCLES_PER_LINE = 200;

    // inputs change this long after the rising edge
    localparam time DRIVE_DELAY = 1ns;

    // one dispatched row per line, 2-bit fields per way with way 0 in the low bits
    // order gives way numbers, first to complete in the low bits
    // src is 0 or 1 for a bus bank, 2 load unit, 3 store/amo unit
    typedef struct packed {
        rob_pkg::way_mask_t valid;
        rob_pkg::way_mask_t rename;
        rob_pkg::way_mask_t ldu;
        rob_pkg::pr_t pr_base;
        logic [7:0] order;
        logic [7:0] src;
        logic [7:0] ack_delay;
    } line_t;

    line_t tbl [TABLE_LINES];

    // ----------------------------------------
    // DUT signals

    logic CLK;
    logic nRST;
    logic dispatch_enq_valid;
    rob_pkg::way_mask_t dispatch_valid_by_way;
    rob_pkg::way_mask_t dispatch_is_rename_by_way;
    rob_pkg::way_mask_t dispatch_is_ldu_by_way;
    rob_pkg::pr_by_way_t dispatch_old_pr_by_way;
    logic dispatch_enq_ready;
    rob_pkg::rob_index_t [rob_pkg::WAYS-1:0] dispatch_rob_index_by_way;
    logic [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank;
    rob_pkg::rob_index_t [rob_pkg::PRF_BANK_COUNT-1:0] complete_bus_rob_index_by_bank;
    logic ldu_complete_valid;
    rob_pkg::rob_index_t ldu_complete_rob_index;
    logic stamofu_complete_valid;
    rob_pkg::rob_index_t stamofu_complete_rob_index;
    logic rob_commit_valid;
    rob_pkg::row_index_t rob_commit_row;
    rob_pkg::way_mask_t rob_commit_way_mask;
    rob_pkg::way_mask_t rob_pr_free_req_valid;
    rob_pkg::pr_by_way_t rob_pr_free_req_pr;
    rob_pkg::way_mask_t rob_pr_free_ack;

    // ----------------------------------------
    // reference model

    // rows in dispatch order, not yet committed
    rob_pkg::row_index_t order_q [$];
    rob_pkg::way_mask_t m_valid [rob_pkg::ROB_ROWS];
    rob_pkg::way_mask_t m_rename [rob_pkg::ROB_ROWS];
    rob_pkg::way_mask_t m_ldu [rob_pkg::ROB_ROWS];
    rob_pkg::way_mask_t m_done [rob_pkg::ROB_ROWS];
    rob_pkg::pr_by_way_t m_pr [rob_pkg::ROB_ROWS];
    int m_line [rob_pkg::ROB_ROWS];
    rob_pkg::row_index_t rows [TABLE_LINES];
    rob_pkg::row_index_t tail;
    rob_pkg::row_index_t free_row;
    rob_pkg::way_mask_t exp_req;
    logic in_free = 1'b0;
    logic hold_acks = 1'b0;
    int wait_cnt [rob_pkg::WAYS];
    int seed = 32'h7e3e;

    tb_clkgen clkgen_i (
        .CLK(CLK),
        .nRST(nRST)
    );

    rob_top dut_i (.*);

    // ----------------------------------------
    // failure reporting and compares

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_row(input string name, input rob_pkg::row_index_t exp,
                             input rob_pkg::row_index_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_index(input string name, input rob_pkg::rob_index_t exp,
                               input rob_pkg::rob_index_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input rob_pkg::way_mask_t exp,
                              input rob_pkg::way_mask_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_pr(input string name, input rob_pkg::pr_t exp, input rob_pkg::pr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // ----------------------------------------
    // stimulus helpers

    // old register of way w is base plus w
    function automatic rob_pkg::pr_by_way_t way_prs(input int line);
        rob_pkg::pr_by_way_t prs;
        for (int w = 0; w < rob_pkg::WAYS; w++) begin
            prs[w] = rob_pkg::pr_t'(int'(tbl[line].pr_base) + w);
        end
        return prs;
    endfunction

    // holds the row until accepted, then records it in the model
    task automatic dispatch_row(input int line);
        @(posedge CLK);
        #DRIVE_DELAY;
        dispatch_enq_valid = 1'b1;
        dispatch_valid_by_way = tbl[line].valid;
        dispatch_is_rename_by_way = tbl[line].rename;
        dispatch_is_ldu_by_way = tbl[line].ldu;
        dispatch_old_pr_by_way = way_prs(line);
        @(negedge CLK);
        while (!dispatch_enq_ready) @(negedge CLK);
        // index is four times the row plus the way
        for (int w = 0; w < rob_pkg::WAYS; w++) begin
            check_index($sformatf("dispatch_rob_index_by_way[%0d]", w),
                        rob_pkg::rob_index_t'(int'(tail) * rob_pkg::WAYS + w),
                        dispatch_rob_index_by_way[w]);
        end
        rows[line] = tail;
        m_valid[tail] = tbl[line].valid;
        m_rename[tail] = tbl[line].rename;
        m_ldu[tail] = tbl[line].ldu;
        m_pr[tail] = way_prs(line);
        m_done[tail] = '0;
        m_line[tail] = line;
        order_q.push_back(tail);
        tail = rob_pkg::row_index_t'((int'(tail) + 1) % rob_pkg::ROB_ROWS);
        @(posedge CLK);
        #DRIVE_DELAY;
        dispatch_enq_valid = 1'b0;
    endtask

    // one completion notice for one cycle
    task automatic send_notice(input logic [1:0] src, input rob_pkg::row_index_t row,
                               input int way);
        rob_pkg::rob_index_t idx;
        idx = rob_pkg::rob_index_t'(int'(row) * rob_pkg::WAYS + way);
        @(posedge CLK);
        #DRIVE_DELAY;
        if (src == 2'd2) begin
            ldu_complete_valid = 1'b1;
            ldu_complete_rob_index = idx;
        end else if (src == 2'd3) begin
            stamofu_complete_valid = 1'b1;
            stamofu_complete_rob_index = idx;
        end else begin
            complete_bus_valid_by_bank[src[0]] = 1'b1;
            complete_bus_rob_index_by_bank[src[0]] = idx;
        end
        // unit notices always complete, the bus only completes non-loads
        if (src[1] || !m_ldu[row][way]) begin
            m_done[row][way] = 1'b1;
        end
        @(posedge CLK);
        #DRIVE_DELAY;
        complete_bus_valid_by_bank = '0;
        ldu_complete_valid = 1'b0;
        stamofu_complete_valid = 1'b0;
    endtask

    task automatic complete_row(input int line, input rob_pkg::row_index_t row);
        int way;
        for (int k = 0; k < rob_pkg::WAYS; k++) begin
            way = int'(tbl[line].order[2*k +: 2]);
            // invalid ways get no notice
            if (tbl[line].valid[way]) begin
                // load sees the bus first, which must not let the row commit
                if (tbl[line].ldu[way]) begin
                    send_notice(2'd0, row, way);
                    repeat (3) @(posedge CLK);
                end
                send_notice(tbl[line].src[2*way +: 2], row, way);
            end
        end
    endtask

    // ----------------------------------------
    // commit and free monitor, also drives acks

    initial begin : commit_monitor
        rob_pkg::way_mask_t next_ack;
        rob_pr_free_ack = '0;
        exp_req = '0;
        forever begin
            @(negedge CLK);
            next_ack = '0;
            if (rob_commit_valid) begin
                if (order_q.size() == 0) begin
                    $display("a commit came with no dispatched row left to retire");
                    stop_run();
                end
                free_row = order_q.pop_front();
                check_row("rob_commit_row", free_row, rob_commit_row);
                check_mask("rob_commit_way_mask", m_valid[free_row], rob_commit_way_mask);
                if ((m_done[free_row] | ~m_valid[free_row]) != '1) begin
                    $display("row %0d committed before all its valid ways completed", free_row);
                    stop_run();
                end
                in_free = 1'b1;
                exp_req = m_valid[free_row] & m_rename[free_row];
                // table delay plus a random extra per bank
                for (int w = 0; w < rob_pkg::WAYS; w++) begin
                    wait_cnt[w] = int'(tbl[m_line[free_row]].ack_delay[2*w +: 2])
                        + ($random(seed) & 3);
                end
            end
            check_mask("rob_pr_free_req_valid", exp_req, rob_pr_free_req_valid);
            for (int w = 0; w < rob_pkg::WAYS; w++) begin
                if (exp_req[w]) begin
                    check_pr($sformatf("rob_pr_free_req_pr[%0d]", w), m_pr[free_row][w],
                             rob_pr_free_req_pr[w]);
                end
            end
            if (in_free && exp_req == '0) begin
                // nothing left to free, row leaves at the coming edge
                in_free = 1'b0;
            end else begin
                // ack now on the bus drops its request at the coming edge
                exp_req = exp_req & ~rob_pr_free_ack;
                for (int w = 0; w < rob_pkg::WAYS; w++) begin
                    if (exp_req[w] && !hold_acks) begin
                        if (wait_cnt[w] == 0) begin
                            next_ack[w] = 1'b1;
                        end else begin
                            wait_cnt[w]--;
                        end
                    end
                end
            end
            @(posedge CLK);
            #DRIVE_DELAY;
            rob_pr_free_ack = next_ack;
        end
    end

    // ----------------------------------------
    // main sequence

    initial begin : stimulus
        dispatch_enq_valid = 1'b0;
        dispatch_valid_by_way = '0;
        dispatch_is_rename_by_way = '0;
        dispatch_is_ldu_by_way = '0;
        dispatch_old_pr_by_way = '0;
        complete_bus_valid_by_bank = '0;
        complete_bus_rob_index_by_bank = '0;
        ldu_complete_valid = 1'b0;
        ldu_complete_rob_index = '0;
        stamofu_complete_valid = 1'b0;
        stamofu_complete_rob_index = '0;
        tail = '0;
        // valid, rename, load, pr base, order, src, ack delay
        tbl[0] = '{4'b1111, 4'b1111, 4'b0001, 7'd16, {2'd0, 2'd1, 2'd2, 2'd3},
                   {2'd0, 2'd3, 2'd1, 2'd2}, {2'd3, 2'd0, 2'd2, 2'd1}};
        tbl[1] = '{4'b0101, 4'b0100, 4'b0001, 7'd24, {2'd3, 2'd1, 2'd0, 2'd2},
                   {2'd0, 2'd1, 2'd0, 2'd2}, {2'd0, 2'd0, 2'd0, 2'd0}};
        tbl[2] = '{4'b1110, 4'b1010, 4'b1000, 7'd32, {2'd0, 2'd3, 2'd2, 2'd1},
                   {2'd2, 2'd0, 2'd3, 2'd0}, {2'd1, 2'd1, 2'd1, 2'd1}};
        tbl[3] = '{4'b1000, 4'b0000, 4'b0000, 7'd40, {2'd0, 2'd1, 2'd2, 2'd3},
                   {2'd1, 2'd0, 2'd0, 2'd0}, {2'd0, 2'd0, 2'd0, 2'd0}};
        tbl[4] = '{4'b1111, 4'b0110, 4'b0110, 7'd48, {2'd3, 2'd0, 2'd2, 2'd1},
                   {2'd1, 2'd2, 2'd2, 2'd0}, {2'd0, 2'd3, 2'd3, 2'd0}};
        tbl[5] = '{4'b0011, 4'b0011, 4'b0000, 7'd56, {2'd3, 2'd2, 2'd0, 2'd1},
                   {2'd0, 2'd0, 2'd1, 2'd1}, {2'd0, 2'd0, 2'd2, 2'd0}};
        tbl[6] = '{4'b1111, 4'b1111, 4'b1111, 7'd64, {2'd1, 2'd3, 2'd0, 2'd2},
                   {2'd2, 2'd2, 2'd2, 2'd2}, {2'd3, 2'd2, 2'd1, 2'd0}};
        tbl[7] = '{4'b0110, 4'b0010, 4'b0000, 7'd120, {2'd0, 2'd3, 2'd1, 2'd2},
                   {2'd0, 2'd0, 2'd3, 2'd0}, {2'd2, 2'd2, 2'd2, 2'd2}};
        wait (nRST === 1'b1);
        @(negedge CLK);
        check_bit("dispatch_enq_ready", 1'b1, dispatch_enq_ready);
        check_bit("rob_commit_valid", 1'b0, rob_commit_valid);
        check_mask("rob_pr_free_req_valid", '0, rob_pr_free_req_valid);
        for (int p = 0; p < PASSES; p++) begin
            // second pass completes each row at once but withholds its frees
            hold_acks = (p == 1);
            for (int i = 0; i < TABLE_LINES; i++) begin
                dispatch_row(i);
                if (p == 1) begin
                    complete_row(i, rows[i]);
                end
            end
            // all 8 rows busy, dispatch has to stall
            repeat (8) begin
                @(negedge CLK);
                check_bit("dispatch_enq_ready", 1'b0, dispatch_enq_ready);
            end
            // newest row first, commits still have to come oldest first
            if (p == 0) begin
                for (int i = TABLE_LINES - 1; i >= 0; i--) begin
                    complete_row(i, rows[i]);
                end
            end
            hold_acks = 1'b0;
            @(negedge CLK);
            while (order_q.size() != 0 || in_free) @(negedge CLK);
            @(negedge CLK);
            check_bit("dispatch_enq_ready", 1'b1, dispatch_enq_ready);
        end
        $display("TEST PASSED");
        $finish;
    end

    // 200 cycles per applied table line
    initial begin : watchdog
        repeat (TABLE_LINES * PASSES * CYCLES_PER_LINE) @(posedge CLK);
        $display("timeout: the scenario table did not finish in the allowed cycles");
        stop_run();
    end

endmodule

// ==== all.f ====
src/rob_pkg.sv
src/rob_alloc_if.sv
src/rob_head_if.sv
src/rob_dispatch.sv
src/rob_row_store.sv
src/rob_commit.sv
src/rob_top.sv
dv/tb_clkgen.sv
dv/rob_asserts.sv
dv/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run, exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f all.f -o rob_sim &&
./obj_dir/rob_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
